// ==== bench/camera_spi_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_spi_tb;
    import camera_spi_pkg::*;

    localparam int SPI_HALF = 10;
    localparam int MAX_CYCLES = 400000;

    logic       clock_in = 1'b0;
    logic       reset_n_in;
    logic       spi_sclk;
    logic       spi_cs_n;
    logic       spi_mosi;
    logic       spi_miso;
    logic       pixel_valid;
    logic [7:0] pixel_red;
    logic [7:0] pixel_green;
    logic [7:0] pixel_blue;

    logic [31:0] lfsr;
    logic [7:0]  rx_bytes [$];
    logic [7:0]  model_luma [FRAME_PIXELS];
    // Center r, g, b then frame r, g, b
    logic [7:0]  model_means [6];
    int          model_quality;
    int          model_available;
    int          model_read;
    int          checks;
    int          errors;

    camera_spi_top UUT (
        .clock_in(clock_in), .reset_n_in(reset_n_in),
        .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .pixel_valid(pixel_valid), .pixel_red(pixel_red),
        .pixel_green(pixel_green), .pixel_blue(pixel_blue)
    );

    always #20 clock_in = ~clock_in;

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic random_bits(input int width, output logic [7:0] value);
        value = 8'd0;
        for (int i = 0; i < width; i++) begin
            value = {value[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [7:0] quantize(input logic [7:0] r, input logic [7:0] g,
                                            input logic [7:0] b, input int quality);
        int luma;
        int drop;
        luma = (int'(r) + 2 * int'(g) + int'(b)) / 4;
        drop = 8 - (1 + quality / 2);
        if (drop < 0) begin
            drop = 0;
        end
        return 8'((luma >> drop) << drop);
    endfunction

    task automatic feed_pixels(input int count);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] gap;
        int         sums [6];
        int         index;
        bit         center;
        index = 0;
        for (int k = 0; k < 6; k++) begin
            sums[k] = 0;
        end
        while (index < count) begin
            random_bits(2, gap);
            if (gap[1:0] == 2'b11) begin
                pixel_valid <= 1'b0;
            end else begin
                random_bits(8, r);
                random_bits(8, g);
                random_bits(8, b);
                if (index < FRAME_PIXELS) begin
                    model_luma[index] = quantize(r, g, b, model_quality);
                    center = (index % FRAME_WIDTH >= CENTER_FIRST)
                          && (index % FRAME_WIDTH <= CENTER_LAST)
                          && (index / FRAME_WIDTH >= CENTER_FIRST)
                          && (index / FRAME_WIDTH <= CENTER_LAST);
                    sums[3] = sums[3] + int'(r);
                    sums[4] = sums[4] + int'(g);
                    sums[5] = sums[5] + int'(b);
                    if (center) begin
                        sums[0] = sums[0] + int'(r);
                        sums[1] = sums[1] + int'(g);
                        sums[2] = sums[2] + int'(b);
                    end
                end
                pixel_valid <= 1'b1;
                pixel_red <= r;
                pixel_green <= g;
                pixel_blue <= b;
                index++;
            end
            @(posedge clock_in);
        end
        pixel_valid <= 1'b0;
        @(posedge clock_in);
        model_available = (count < FRAME_PIXELS) ? count : FRAME_PIXELS;
        // Means only move when a whole frame arrived
        if (count >= FRAME_PIXELS) begin
            for (int k = 0; k < 3; k++) begin
                model_means[k] = 8'(sums[k] / CENTER_PIXELS);
                model_means[k + 3] = 8'(sums[k + 3] / FRAME_PIXELS);
            end
        end
    endtask

    // Mode 0, MOSI set while SCLK low, MISO taken just before the rise
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi <= tx[i];
            repeat (SPI_HALF) @(posedge clock_in);
            rx[i] = spi_miso;
            spi_sclk <= 1'b1;
            repeat (SPI_HALF) @(posedge clock_in);
            spi_sclk <= 1'b0;
        end
    endtask

    task automatic spi_transaction(input logic [7:0] op, input int count,
                                   input logic [7:0] fill);
        logic [7:0] rx;
        rx_bytes.delete();
        spi_cs_n <= 1'b0;
        repeat (SPI_HALF) @(posedge clock_in);
        spi_byte(op, rx);
        for (int k = 0; k < count; k++) begin
            spi_byte(fill, rx);
            rx_bytes.push_back(rx);
        end
        repeat (SPI_HALF) @(posedge clock_in);
        spi_cs_n <= 1'b1;
        repeat (2 * SPI_HALF) @(posedge clock_in);
    endtask

    task automatic check_byte(input string name, input int k, input logic [7:0] expected);
        checks++;
        assert (rx_bytes[k] == expected) else begin
            errors++;
            $display("error: %s byte %0d expected %02h actual %02h",
                     name, k, expected, rx_bytes[k]);
        end
    endtask

    task automatic run_test(input string name, input logic [7:0] opcode, input int count,
                            input logic [7:0] operand, input string mode,
                            input logic [15:0] value);
        logic [7:0] expected;
        if (opcode == OP_QUALITY && count > 0) begin
            model_quality = int'(operand[3:0]);
        end
        if (opcode == OP_CAPTURE) begin
            model_read = 0;
            model_available = 0;
        end
        spi_transaction(opcode, count, operand);
        for (int k = 0; k < count; k++) begin
            if (mode == "const") begin
                check_byte(name, k, value[7:0]);
            end else if (mode == "count") begin
                check_byte(name, k, (k == 0) ? value[15:8] : value[7:0]);
            end else if (mode == "means") begin
                check_byte(name, k, (k < 6) ? model_means[k] : 8'hFF);
            end else if (mode == "luma") begin
                expected = 8'd0;
                if (model_read < model_available) begin
                    expected = model_luma[model_read];
                    model_read++;
                end
                check_byte(name, k, expected);
            end
        end
        if (mode == "pixels") begin
            feed_pixels(int'(value));
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        int          waited;
        int          count;
        string       line;
        string       name;
        string       mode;
        logic [7:0]  opcode;
        logic [7:0]  operand;
        logic [15:0] value;
        reset_n_in = 1'b0;
        spi_sclk = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        pixel_valid = 1'b0;
        pixel_red = 8'd0;
        pixel_green = 8'd0;
        pixel_blue = 8'd0;
        lfsr = 32'h228cd03e;
        model_quality = 0;
        model_available = 0;
        model_read = 0;
        checks = 0;
        errors = 0;
        for (int k = 0; k < 6; k++) begin
            model_means[k] = 8'd0;
        end
        repeat (10) @(posedge clock_in);
        reset_n_in <= 1'b1;
        waited = 0;
        while (spi_miso !== 1'b1 && waited < 20) begin
            @(posedge clock_in);
            waited++;
        end
        assert (spi_miso === 1'b1) else begin
            errors++;
            $display("MISO did not idle high within 20 cycles after reset");
        end
        fd = $fopen("bench/camera_spi_tests.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("Could not open bench/camera_spi_tests.txt");
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %h %h %h %s %h",
                                 name, opcode, count, operand, mode, value);
                assert (fields == 6) else begin
                    errors++;
                    $display("Test file line could not be parsed: %s", line);
                end
                if (fields == 6) begin
                    run_test(name, opcode, count, operand, mode, value);
                end
            end
            $fclose(fd);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog for the whole run
    initial begin
        repeat (MAX_CYCLES) @(posedge clock_in);
        $display("Simulation did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/camera_spi_tests.txt ====
# name opcode operand_count operand check value, numbers in hex, operand repeats per byte
# check is none, const, count (high then low), luma or means (frame model), pixels (fed after)
avail_after_reset   21 02 00 count  0000
unknown_opcode      30 02 00 const  00ff
read_before_capture 22 02 00 luma   0000
quality_7           26 01 07 none   0000
capture_q7          20 00 00 pixels 0048
avail_full          21 02 00 count  0040
read_first_five     22 05 00 luma   0000
avail_after_five    21 02 00 count  003b
metering_q7         25 06 00 means  0000
read_remaining      22 3b 00 luma   0000
read_past_end       22 04 00 luma   0000
avail_empty         21 02 00 count  0000
quality_0           26 01 00 none   0000
capture_q0          20 00 00 pixels 0040
avail_recapture     21 02 00 count  0040
read_q0             22 10 00 luma   0000
metering_q0         25 06 00 means  0000
quality_15          26 01 0f none   0000
capture_q15         20 00 00 pixels 0043
avail_pointer_reset 21 02 00 count  0040
read_q15_all        22 40 00 luma   0000
avail_q15_done      21 02 00 count  0000
metering_q15        25 06 00 means  0000
zoom_reserved       23 03 00 const  00ff

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module camera_spi_tb -o camera_spi_sim -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/camera_spi_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0

// ==== src/camera_spi_pkg.sv ====
`default_nettype none

package camera_spi_pkg;

    // SPI opcodes
    localparam logic [7:0] OP_CAPTURE = 8'h20;
    localparam logic [7:0] OP_BYTES_AVAILABLE = 8'h21;
    localparam logic [7:0] OP_READ_DATA = 8'h22;
    localparam logic [7:0] OP_METERING = 8'h25;
    localparam logic [7:0] OP_QUALITY = 8'h26;

    // Frame geometry, raster order
    localparam int FRAME_WIDTH = 8;
    localparam int FRAME_HEIGHT = 8;
    localparam int FRAME_PIXELS = 64;

    // Width of the byte counters
    localparam int COUNT_WIDTH = 16;

    // Center window, inclusive for both column and row
    localparam int CENTER_FIRST = 2;
    localparam int CENTER_LAST = 5;
    localparam int CENTER_PIXELS = 16;

    // Shifted out when no response is ready
    localparam logic [7:0] IDLE_BYTE = 8'hFF;

endpackage

`default_nettype wire

// ==== src/camera_spi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_spi_top (
    input  logic       clock_in,
    input  logic       reset_n_in,
    input  logic       spi_sclk,
    input  logic       spi_cs_n,
    input  logic       spi_mosi,
    output logic       spi_miso,
    input  logic       pixel_valid,
    input  logic [7:0] pixel_red,
    input  logic [7:0] pixel_green,
    input  logic [7:0] pixel_blue
);
    import camera_spi_pkg::*;

    logic [7:0]             op_code;
    logic                   op_code_valid;
    logic [7:0]             operand;
    logic                   operand_valid;
    integer                 operand_count;
    logic [7:0]             response;
    logic                   response_valid;
    logic                   start_capture;
    logic [3:0]             quality_factor;
    logic [COUNT_WIDTH-1:0] bytes_available;
    logic [COUNT_WIDTH-1:0] bytes_read;
    logic [7:0]             data;
    logic [7:0]             red_center;
    logic [7:0]             green_center;
    logic [7:0]             blue_center;
    logic [7:0]             red_average;
    logic [7:0]             green_average;
    logic [7:0]             blue_average;

    spi_byte_link link (
        .clock_in(clock_in), .reset_n_in(reset_n_in),
        .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .response(response), .response_valid(response_valid),
        .op_code(op_code), .op_code_valid(op_code_valid),
        .operand(operand), .operand_valid(operand_valid), .operand_count(operand_count)
    );

    spi_registers registers (
        .clock_in(clock_in), .reset_n_in(reset_n_in),
        .op_code(op_code), .op_code_valid(op_code_valid),
        .operand(operand), .operand_valid(operand_valid), .operand_count(operand_count),
        .response(response), .response_valid(response_valid),
        .start_capture(start_capture), .quality_factor(quality_factor),
        .bytes_available(bytes_available), .data(data), .bytes_read(bytes_read),
        .red_center(red_center), .green_center(green_center), .blue_center(blue_center),
        .red_average(red_average), .green_average(green_average),
        .blue_average(blue_average)
    );

    frame_buffer buffer (
        .clock_in(clock_in), .reset_n_in(reset_n_in),
        .start_capture(start_capture), .quality_factor(quality_factor),
        .pixel_valid(pixel_valid), .pixel_red(pixel_red),
        .pixel_green(pixel_green), .pixel_blue(pixel_blue),
        .bytes_read(bytes_read), .bytes_available(bytes_available), .data(data)
    );

    color_metering metering (
        .clock_in(clock_in), .reset_n_in(reset_n_in),
        .start_capture(start_capture), .pixel_valid(pixel_valid),
        .pixel_red(pixel_red), .pixel_green(pixel_green), .pixel_blue(pixel_blue),
        .red_center(red_center), .green_center(green_center), .blue_center(blue_center),
        .red_average(red_average), .green_average(green_average),
        .blue_average(blue_average)
    );

endmodule

`default_nettype wire

// ==== src/color_metering.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_metering (
    input  logic       clock_in,
    input  logic       reset_n_in,
    input  logic       start_capture,
    input  logic       pixel_valid,
    input  logic [7:0] pixel_red,
    input  logic [7:0] pixel_green,
    input  logic [7:0] pixel_blue,
    output logic [7:0] red_center,
    output logic [7:0] green_center,
    output logic [7:0] blue_center,
    output logic [7:0] red_average,
    output logic [7:0] green_average,
    output logic [7:0] blue_average
);
    import camera_spi_pkg::*;

    logic [7:0]                          pixel [3];
    logic [8+$clog2(FRAME_PIXELS)-1:0]   frame_sum [3];
    logic [8+$clog2(FRAME_PIXELS)-1:0]   frame_next [3];
    logic [8+$clog2(CENTER_PIXELS)-1:0]  center_sum [3];
    logic [8+$clog2(CENTER_PIXELS)-1:0]  center_next [3];
    logic [7:0]                          frame_mean [3];
    logic [7:0]                          center_mean [3];
    int unsigned                         column;
    int unsigned                         row;
    logic                                armed;
    logic                                in_center;
    logic                                last_pixel;

    assign pixel[0] = pixel_red;
    assign pixel[1] = pixel_green;
    assign pixel[2] = pixel_blue;

    assign in_center = (column >= CENTER_FIRST) && (column <= CENTER_LAST)
                    && (row >= CENTER_FIRST) && (row <= CENTER_LAST);
    assign last_pixel = (column == FRAME_WIDTH - 1) && (row == FRAME_HEIGHT - 1);

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            frame_next[c] = frame_sum[c] + (8 + $clog2(FRAME_PIXELS))'(pixel[c]);
            center_next[c] = center_sum[c]
                           + (8 + $clog2(CENTER_PIXELS))'(in_center ? pixel[c] : 8'd0);
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            armed <= 1'b0;
            column <= 0;
            row <= 0;
            for (int c = 0; c < 3; c++) begin
                frame_mean[c] <= 8'd0;
                center_mean[c] <= 8'd0;
            end
        end else if (start_capture) begin
            armed <= 1'b1;
            column <= 0;
            row <= 0;
            for (int c = 0; c < 3; c++) begin
                frame_sum[c] <= '0;
                center_sum[c] <= '0;
            end
        end else if (armed && pixel_valid) begin
            for (int c = 0; c < 3; c++) begin
                frame_sum[c] <= frame_next[c];
                center_sum[c] <= center_next[c];
            end
            if (column == FRAME_WIDTH - 1) begin
                column <= 0;
                row <= row + 1;
            end else begin
                column <= column + 1;
            end
            // Means held until the next frame completes
            if (last_pixel) begin
                armed <= 1'b0;
                for (int c = 0; c < 3; c++) begin
                    frame_mean[c] <= frame_next[c][$clog2(FRAME_PIXELS) +: 8];
                    center_mean[c] <= center_next[c][$clog2(CENTER_PIXELS) +: 8];
                end
            end
        end
    end

    assign red_center = center_mean[0];
    assign green_center = center_mean[1];
    assign blue_center = center_mean[2];
    assign red_average = frame_mean[0];
    assign green_average = frame_mean[1];
    assign blue_average = frame_mean[2];

endmodule

`default_nettype wire

// ==== src/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic                               clock_in,
    input  logic                               reset_n_in,
    input  logic                               start_capture,
    input  logic [3:0]                         quality_factor,
    input  logic                               pixel_valid,
    input  logic [7:0]                         pixel_red,
    input  logic [7:0]                         pixel_green,
    input  logic [7:0]                         pixel_blue,
    input  logic [camera_spi_pkg::COUNT_WIDTH-1:0] bytes_read,
    output logic [camera_spi_pkg::COUNT_WIDTH-1:0] bytes_available,
    output logic [7:0]                         data
);
    import camera_spi_pkg::*;

    logic [7:0] mem [FRAME_PIXELS];
    logic       armed;
    logic [9:0] luma_sum;
    logic [3:0] keep_bits;
    logic [7:0] keep_mask;

    // Luma as (r + 2g + b) / 4
    assign luma_sum = {2'b00, pixel_red} + {1'b0, pixel_green, 1'b0} + {2'b00, pixel_blue};

    // 1 + qf/2 bits kept, at most 8 for a 4-bit factor
    assign keep_bits = {1'b0, quality_factor[3:1]} + 4'd1;
    assign keep_mask = 8'hFF << (4'd8 - keep_bits);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            armed <= 1'b0;
            bytes_available <= '0;
        end else if (start_capture) begin
            armed <= 1'b1;
            bytes_available <= '0;
        end else if (armed && pixel_valid) begin
            mem[bytes_available[$clog2(FRAME_PIXELS)-1:0]] <= luma_sum[9:2] & keep_mask;
            bytes_available <= bytes_available + COUNT_WIDTH'(1);
            if (bytes_available == COUNT_WIDTH'(FRAME_PIXELS - 1)) begin
                armed <= 1'b0;
            end
        end
    end

    assign data = (bytes_read < bytes_available)
                ? mem[bytes_read[$clog2(FRAME_PIXELS)-1:0]] : 8'd0;

    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        bytes_available <= COUNT_WIDTH'(FRAME_PIXELS));

endmodule

`default_nettype wire

// ==== src/spi_byte_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_byte_link (
    input  logic       clock_in,
    input  logic       reset_n_in,
    input  logic       spi_sclk,
    input  logic       spi_cs_n,
    input  logic       spi_mosi,
    output logic       spi_miso,
    input  logic [7:0] response,
    input  logic       response_valid,
    output logic [7:0] op_code,
    output logic       op_code_valid,
    output logic [7:0] operand,
    output logic       operand_valid,
    output integer     operand_count
);
    import camera_spi_pkg::*;

    logic [1:0] sclk_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_count;
    logic [6:0] rx_shift;
    logic [7:0] rx_byte;
    logic [7:0] tx_shift;
    logic       load_pending;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            sclk_sync <= 2'b00;
            cs_n_sync <= 2'b11;
            mosi_sync <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign rx_byte = {rx_shift, mosi_sync[1]};
    assign spi_miso = tx_shift[7];

    // Deselect drops the whole frame state
    always_ff @(posedge clock_in) begin
        if (!reset_n_in || cs_n_sync[1]) begin
            bit_count <= 3'd0;
            op_code_valid <= 1'b0;
            operand_valid <= 1'b0;
            operand_count <= 0;
            tx_shift <= IDLE_BYTE;
            load_pending <= 1'b0;
        end else begin
            operand_valid <= 1'b0;
            if (sclk_rise) begin
                rx_shift <= rx_byte[6:0];
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    load_pending <= 1'b1;
                    if (op_code_valid) begin
                        operand <= rx_byte;
                        operand_valid <= 1'b1;
                        operand_count <= operand_count + 1;
                    end else begin
                        op_code <= rx_byte;
                        op_code_valid <= 1'b1;
                    end
                end
            end
            // MISO changes on falling SCLK, new byte at the boundary
            if (sclk_fall) begin
                load_pending <= 1'b0;
                if (load_pending) begin
                    tx_shift <= response_valid ? response : IDLE_BYTE;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b1};
                end
            end
        end
    end

    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        operand_valid |=> !operand_valid);
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        operand_valid |-> op_code_valid);

endmodule

`default_nettype wire

// ==== src/spi_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_registers (
    input  logic                               clock_in,
    input  logic                               reset_n_in,
    input  logic [7:0]                         op_code,
    input  logic                               op_code_valid,
    input  logic [7:0]                         operand,
    input  logic                               operand_valid,
    input  integer                             operand_count,
    output logic [7:0]                         response,
    output logic                               response_valid,
    output logic                               start_capture,
    output logic [3:0]                         quality_factor,
    input  logic [camera_spi_pkg::COUNT_WIDTH-1:0] bytes_available,
    input  logic [7:0]                         data,
    output logic [camera_spi_pkg::COUNT_WIDTH-1:0] bytes_read,
    input  logic [7:0]                         red_center,
    input  logic [7:0]                         green_center,
    input  logic [7:0]                         blue_center,
    input  logic [7:0]                         red_average,
    input  logic [7:0]                         green_average,
    input  logic [7:0]                         blue_average
);
    import camera_spi_pkg::*;

    logic [COUNT_WIDTH-1:0] bytes_remaining;
    logic [1:0]             operand_edge;
    logic                   op_code_seen;

    assign bytes_remaining = bytes_available - bytes_read;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            response_valid <= 1'b0;
            start_capture <= 1'b0;
            quality_factor <= 4'd0;
            bytes_read <= '0;
            operand_edge <= 2'b00;
            op_code_seen <= 1'b0;
        end else begin
            operand_edge <= {operand_edge[0], operand_valid};
            op_code_seen <= op_code_valid;
            start_capture <= 1'b0;
            response_valid <= 1'b0;
            if (op_code_valid) begin
                case (op_code)
                    OP_CAPTURE: begin
                        // Single pulse on the opcode's first cycle only
                        if (!op_code_seen) begin
                            start_capture <= 1'b1;
                            bytes_read <= '0;
                        end
                    end
                    OP_BYTES_AVAILABLE: begin
                        response <= (operand_count == 0) ? bytes_remaining[15:8]
                                                         : bytes_remaining[7:0];
                        response_valid <= 1'b1;
                    end
                    OP_READ_DATA: begin
                        response <= data;
                        response_valid <= 1'b1;
                        if (operand_edge == 2'b01 && bytes_read < bytes_available) begin
                            bytes_read <= bytes_read + COUNT_WIDTH'(1);
                        end
                    end
                    OP_METERING: begin
                        case (operand_count)
                            0: response <= red_center;
                            1: response <= green_center;
                            2: response <= blue_center;
                            3: response <= red_average;
                            4: response <= green_average;
                            5: response <= blue_average;
                            default: response <= IDLE_BYTE;
                        endcase
                        response_valid <= 1'b1;
                    end
                    OP_QUALITY: begin
                        if (operand_valid) begin
                            quality_factor <= operand[3:0];
                        end
                    end
                    default: begin
                        response_valid <= 1'b0;
                    end
                endcase
            end
        end
    end

    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        start_capture |=> !start_capture);
    // Pointer may trail the buffer count but never pass it
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        bytes_read <= bytes_available);

endmodule

`default_nettype wire

// ==== verilog.f ====
src/camera_spi_pkg.sv
src/spi_byte_link.sv
src/spi_registers.sv
src/frame_buffer.sv
src/color_metering.sv
src/camera_spi_top.sv
bench/camera_spi_tb.sv
